// File: pcpi_pkg.sv
package pcpi_pkg;

	// One architectural register value
	typedef logic [31:0] word_t;

	// Request as presented by the core
	// All fields stay steady from the rise of valid until the core sees ready
	typedef struct packed {
		logic  valid;
		word_t insn;
		word_t rs1;
		word_t rs2;
	} pcpi_req_t;

	// Response from one execution unit, or from the merge towards the core
	// The PCPI wait level is called waiting because wait is a reserved word
	typedef struct packed {
		logic  wr;
		word_t rd;
		logic  waiting;
		logic  ready;
	} pcpi_resp_t;

endpackage

// File: muldiv_pkg.sv
package muldiv_pkg;

	typedef logic [6:0] opcode_t;
	typedef logic [6:0] funct7_t;

	// Register-register ALU opcode, and the funct7 that selects the M group in it
	localparam opcode_t OPCODE_OP     = 7'b0110011;
	localparam funct7_t FUNCT7_MULDIV = 7'b0000001;

	// funct3 inside the M group
	// Bit 2 separates the multiply forms from the divide forms
	typedef enum logic [2:0] {
		MUL    = 3'b000,
		MULH   = 3'b001,
		MULHSU = 3'b010,
		MULHU  = 3'b011,
		DIV    = 3'b100,
		DIVU   = 3'b101,
		REM    = 3'b110,
		REMU   = 3'b111
	} muldiv_op_e;

	// One DSP slice takes two 18-bit signed operands and gives a 36-bit product
	typedef logic signed [17:0] dsp_operand_t;
	typedef logic signed [35:0] dsp_product_t;

	// One quotient bit is produced per iteration
	localparam int DIV_STEPS = 32;

	typedef logic [$clog2(DIV_STEPS)-1:0] div_count_t;

	typedef enum logic [1:0] {
		DIV_IDLE,
		DIV_RUN,
		DIV_DONE,
		DIV_HOLD
	} div_state_e;

endpackage

// File: mul_18x18.sv
`timescale 1ns/1ps

module mul_18x18
	import muldiv_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  dsp_operand_t a,
	input  dsp_operand_t b,
	output dsp_product_t dout
);

	// The output register stands for the slice's own pipeline register
	always_ff @(posedge clk) begin
		if (reset) begin
			dout <= '0;
		end else begin
			dout <= a * b;
		end
	end

endmodule

// File: pcpi_fastmul_dsp.sv
`timescale 1ns/1ps

module pcpi_fastmul_dsp
	import pcpi_pkg::*, muldiv_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  pcpi_req_t  req,
	output pcpi_resp_t resp
);

	muldiv_op_e op;
	logic insn_mul;
	logic start;
	logic rs1_signed;
	logic rs2_signed;

	dsp_operand_t rs1_hi;
	dsp_operand_t rs1_lo;
	dsp_operand_t rs2_hi;
	dsp_operand_t rs2_lo;

	dsp_product_t p_hh;
	dsp_product_t p_hl;
	dsp_product_t p_lh;
	dsp_product_t p_ll;
	logic [63:0] total;

	logic in_flight;
	logic done_wait;
	logic ready;
	logic low_word;
	word_t rd;

	function automatic logic [63:0] widen(dsp_product_t p);
		return {{28{p[35]}}, p};
	endfunction

	assign op = muldiv_op_e'(req.insn[14:12]);

	assign insn_mul = req.valid
		&& req.insn[6:0] == OPCODE_OP
		&& req.insn[31:25] == FUNCT7_MULDIV
		&& !req.insn[14];

	// No restart while a product is on its way or the last result is still claimed
	assign start = insn_mul && !in_flight && !done_wait;

	assign rs1_signed = (op == MULH) || (op == MULHSU);
	assign rs2_signed = (op == MULH);

	// Upper halves carry the sign of the operand when that operand is signed
	assign rs1_hi = {{2{rs1_signed & req.rs1[31]}}, req.rs1[31:16]};
	assign rs2_hi = {{2{rs2_signed & req.rs2[31]}}, req.rs2[31:16]};
	assign rs1_lo = {2'b00, req.rs1[15:0]};
	assign rs2_lo = {2'b00, req.rs2[15:0]};

	mul_18x18 hh (
		.clk   (clk),
		.reset (reset),
		.a     (rs1_hi),
		.b     (rs2_hi),
		.dout  (p_hh)
	);

	mul_18x18 hl (
		.clk   (clk),
		.reset (reset),
		.a     (rs1_hi),
		.b     (rs2_lo),
		.dout  (p_hl)
	);

	mul_18x18 lh (
		.clk   (clk),
		.reset (reset),
		.a     (rs1_lo),
		.b     (rs2_hi),
		.dout  (p_lh)
	);

	mul_18x18 ll (
		.clk   (clk),
		.reset (reset),
		.a     (rs1_lo),
		.b     (rs2_lo),
		.dout  (p_ll)
	);

	assign total = (widen(p_hh) << 32)
		+ (widen(p_hl) << 16)
		+ (widen(p_lh) << 16)
		+ widen(p_ll);

	always_ff @(posedge clk) begin
		if (reset) begin
			in_flight <= 1'b0;
			done_wait <= 1'b0;
			ready     <= 1'b0;
		end else begin
			ready <= in_flight;
			if (start) begin
				in_flight <= 1'b1;
			end else if (in_flight) begin
				in_flight <= 1'b0;
				done_wait <= 1'b1;
			end else if (done_wait && !req.valid) begin
				done_wait <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			low_word <= (op == MUL);
		end
		if (in_flight) begin
			rd <= low_word ? total[31:0] : total[63:32];
		end
	end

	// Fixed two-edge latency, so the core is never asked to wait
	assign resp = '{wr: ready, rd: rd, waiting: 1'b0, ready: ready};

endmodule

// File: pcpi_div_seq.sv
`timescale 1ns/1ps

module pcpi_div_seq
	import pcpi_pkg::*, muldiv_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  pcpi_req_t  req,
	output pcpi_resp_t resp
);

	div_state_e state;
	div_count_t count;
	logic ready;
	word_t rd;

	muldiv_op_e op;
	logic insn_div;
	logic start;
	logic signed_op;
	logic rem_op;

	word_t quo;
	word_t rem;
	word_t divisor;
	logic want_rem;
	logic neg_quo;
	logic neg_rem;
	logic div_zero;
	logic overflow;

	logic [32:0] shifted;
	logic [33:0] trial;
	word_t quo_fix;
	word_t rem_fix;

	assign op = muldiv_op_e'(req.insn[14:12]);

	assign insn_div = req.valid
		&& req.insn[6:0] == OPCODE_OP
		&& req.insn[31:25] == FUNCT7_MULDIV
		&& req.insn[14];

	assign start = insn_div && state == DIV_IDLE;
	assign signed_op = (op == DIV) || (op == REM);
	assign rem_op = (op == REM) || (op == REMU);

	// Restoring step: shift the next dividend bit in and try to subtract the divisor
	assign shifted = {rem, quo[31]};
	assign trial = {1'b0, shifted} - {2'b00, divisor};

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= DIV_IDLE;
			count <= '0;
			ready <= 1'b0;
		end else begin
			ready <= 1'b0;
			case (state)
				DIV_IDLE: begin
					if (start) begin
						state <= DIV_RUN;
						count <= '0;
					end
				end
				DIV_RUN: begin
					count <= count + 1'b1;
					if (count == div_count_t'(DIV_STEPS - 1)) begin
						state <= DIV_DONE;
					end
				end
				DIV_DONE: begin
					ready <= 1'b1;
					state <= DIV_HOLD;
				end
				DIV_HOLD: begin
					if (!req.valid) begin
						state <= DIV_IDLE;
					end
				end
				default: state <= DIV_IDLE;
			endcase
		end
	end

	// A zero divisor runs through the loop unchanged and leaves the dividend in rem,
	// so only the quotient needs forcing
	always_comb begin
		quo_fix = neg_quo ? -quo : quo;
		rem_fix = neg_rem ? -rem : rem;
		if (div_zero) begin
			quo_fix = '1;
		end
		if (overflow) begin
			quo_fix = 32'h8000_0000;
			rem_fix = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			quo      <= (signed_op && req.rs1[31]) ? -req.rs1 : req.rs1;
			divisor  <= (signed_op && req.rs2[31]) ? -req.rs2 : req.rs2;
			rem      <= '0;
			want_rem <= rem_op;
			neg_quo  <= signed_op && (req.rs1[31] ^ req.rs2[31]);
			neg_rem  <= signed_op && req.rs1[31];
			div_zero <= req.rs2 == '0;
			overflow <= signed_op && req.rs1 == 32'h8000_0000 && req.rs2 == '1;
		end else if (state == DIV_RUN) begin
			if (!trial[33]) begin
				rem <= trial[31:0];
				quo <= {quo[30:0], 1'b1};
			end else begin
				rem <= shifted[31:0];
				quo <= {quo[30:0], 1'b0};
			end
		end else if (state == DIV_DONE) begin
			rd <= want_rem ? rem_fix : quo_fix;
		end
	end

	assign resp = '{
		wr: ready,
		rd: rd,
		waiting: (state == DIV_RUN) || (state == DIV_DONE),
		ready: ready
	};

endmodule

// File: pcpi_resp_merge.sv
`timescale 1ns/1ps

module pcpi_resp_merge
	import pcpi_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  pcpi_resp_t mul_resp,
	input  pcpi_resp_t div_resp,
	output pcpi_resp_t resp
);

	logic unit_ready;
	logic unit_wait;
	logic was_busy;
	logic pending;
	logic ready;
	word_t rd;

	// Only one instruction is in progress at a time, so at most one unit is ready
	assign unit_ready = mul_resp.ready | div_resp.ready;
	assign unit_wait = mul_resp.waiting | div_resp.waiting;

	// A unit drops its wait together with its ready, one cycle before ours.
	// Bridge that cycle only when the unit had been waiting, so a multiply
	// never shows wait at all.
	assign pending = was_busy & unit_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			ready    <= 1'b0;
			was_busy <= 1'b0;
		end else begin
			ready    <= unit_ready;
			was_busy <= unit_wait;
		end
	end

	always_ff @(posedge clk) begin
		if (unit_ready) begin
			rd <= mul_resp.ready ? mul_resp.rd : div_resp.rd;
		end
	end

	assign resp = '{
		wr: ready,
		rd: rd,
		waiting: unit_wait | pending,
		ready: ready
	};

endmodule

// File: pcpi_muldiv.sv
`timescale 1ns/1ps

module pcpi_muldiv
	import pcpi_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  pcpi_req_t  req,
	output pcpi_resp_t resp
);

	pcpi_resp_t mul_resp;
	pcpi_resp_t div_resp;

	// Both units see every request and each claims only its own funct3 group
	pcpi_fastmul_dsp u_mul (
		.clk   (clk),
		.reset (reset),
		.req   (req),
		.resp  (mul_resp)
	);

	pcpi_div_seq u_div (
		.clk   (clk),
		.reset (reset),
		.req   (req),
		.resp  (div_resp)
	);

	pcpi_resp_merge u_merge (
		.clk      (clk),
		.reset    (reset),
		.mul_resp (mul_resp),
		.div_resp (div_resp),
		.resp     (resp)
	);

endmodule

// File: pcpi_muldiv_chk.sv
`timescale 1ns/1ps

module pcpi_muldiv_chk
	import pcpi_pkg::*;
(
	input logic       clk,
	input logic       reset,
	input pcpi_resp_t resp
);

	// The core expects ready as a single-cycle pulse
	ready_pulse: assert property (@(posedge clk) disable iff (reset)
		resp.ready |=> !resp.ready)
		else $error("ready stayed high for two consecutive cycles");

	wr_follows_ready: assert property (@(posedge clk) disable iff (reset)
		resp.wr == resp.ready)
		else $error("wr differs from ready");

	// Covers every cycle of reset after the first edge
	ready_low_in_reset: assert property (@(posedge clk)
		reset |=> !resp.ready)
		else $error("ready high while reset was applied");

	ready_low_after_reset: assert property (@(posedge clk)
		$fell(reset) |=> !resp.ready)
		else $error("ready high in the cycle after reset was released");

	wait_drops_after_ready: assert property (@(posedge clk) disable iff (reset)
		resp.ready |=> !resp.waiting)
		else $error("wait high in the cycle after ready");

endmodule

bind pcpi_muldiv pcpi_muldiv_chk u_chk (
	.clk   (clk),
	.reset (reset),
	.resp  (resp)
);

// File: tb_pcpi_muldiv.sv
`timescale 1ns/1ps

module tb_pcpi_muldiv
	import pcpi_pkg::*, muldiv_pkg::*;
();

	typedef struct packed {
		logic [2:0] funct3;
		word_t      rs1;
		word_t      rs2;
		word_t      rd;
	} vector_t;

	logic       clk;
	logic       reset;
	pcpi_req_t  req;
	pcpi_resp_t resp;

	vector_t vectors[$];
	string   vector_names[$];
	integer  seed;
	int      errors;
	int      checks;
	int      i;
	logic [2:0] f3;
	word_t   a;
	word_t   b;

	pcpi_muldiv u_dut (
		.clk   (clk),
		.reset (reset),
		.req   (req),
		.resp  (resp)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic word_t encode_insn(input logic [6:0] funct7, input logic [2:0] funct3,
			input logic [6:0] opcode);
		return {funct7, 5'd2, 5'd1, funct3, 5'd3, opcode};
	endfunction

	// Reference result from the RISC-V M rules with 64-bit arithmetic.
	// A zero-extended unsigned operand is positive in 64 bits, so one signed divide serves all forms
	function automatic word_t model_rd(input logic [2:0] funct3, input word_t x, input word_t y);
		logic x_signed;
		logic y_signed;
		logic signed [63:0] xl;
		logic signed [63:0] yl;
		logic signed [63:0] r;
		x_signed = funct3 == 3'b001 || funct3 == 3'b010 || funct3 == 3'b100 || funct3 == 3'b110;
		y_signed = funct3 == 3'b001 || funct3 == 3'b100 || funct3 == 3'b110;
		xl = {{32{x_signed & x[31]}}, x};
		yl = {{32{y_signed & y[31]}}, y};
		if (!funct3[2]) begin
			r = xl * yl;
			return (funct3 == 3'b000) ? r[31:0] : r[63:32];
		end
		if (y == 32'h0) begin
			return funct3[1] ? x : 32'hffff_ffff;
		end
		// Most negative by minus one gives 2^31 and 0 here, which matches the overflow rule
		r = funct3[1] ? xl % yl : xl / yl;
		return r[31:0];
	endfunction

	task automatic add_vector(input string name, input logic [2:0] funct3, input word_t x,
			input word_t y, input word_t rd);
		vectors.push_back('{funct3: funct3, rs1: x, rs2: y, rd: rd});
		vector_names.push_back(name);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic run_op(input string name, input logic [2:0] funct3, input word_t x,
			input word_t y, input word_t expected);
		int cycles;
		int latency;
		logic saw_wait;
		cycles = 0;
		saw_wait = 1'b0;
		latency = funct3[2] ? 35 : 3;
		req = '{valid: 1'b1, insn: encode_insn(7'b0000001, funct3, 7'b0110011), rs1: x, rs2: y};
		do begin
			@(posedge clk);
			#1;
			cycles++;
			saw_wait = saw_wait | resp.waiting;
		end while (!resp.ready && cycles < 60);
		checks++;
		if (!resp.ready) begin
			errors++;
			$display("%s: no ready within 60 cycles", name);
		end else begin
			checks += 2;
			if (resp.rd !== expected) begin
				errors++;
				$display("Error: %s expected %h actual %h", name, expected, resp.rd);
			end
			if (cycles != latency) begin
				errors++;
				$display("Error: %s latency expected %0d actual %0d", name, latency, cycles);
			end
		end
		// Only a divide is allowed to show wait before its ready
		checks++;
		if (saw_wait !== funct3[2]) begin
			errors++;
			$display("Error: %s wait seen expected %b actual %b", name, funct3[2], saw_wait);
		end
		req.valid = 1'b0;
		idle_cycles(2);
	endtask

	task automatic run_unclaimed(input string name, input word_t insn);
		logic saw_ready;
		logic saw_wait;
		saw_ready = 1'b0;
		saw_wait = 1'b0;
		req = '{valid: 1'b1, insn: insn, rs1: 32'h0000_0064, rs2: 32'h0000_0007};
		for (int n = 0; n < 40; n++) begin
			@(posedge clk);
			#1;
			saw_ready = saw_ready | resp.ready;
			saw_wait = saw_wait | resp.waiting;
		end
		checks += 2;
		if (saw_ready) begin
			errors++;
			$display("%s: a unit answered an instruction outside the M group", name);
		end
		if (saw_wait) begin
			errors++;
			$display("%s: wait went high for an instruction outside the M group", name);
		end
		req.valid = 1'b0;
		idle_cycles(2);
	endtask

	initial begin
		seed = 95;
		errors = 0;
		checks = 0;
		reset = 1'b1;
		req = '0;
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;
		idle_cycles(2);

		add_vector("mul_zero", MUL, 32'h0000_0000, 32'h1234_5678, 32'h0000_0000);
		add_vector("mul_ones", MUL, 32'hffff_ffff, 32'hffff_ffff, 32'h0000_0001);
		add_vector("mul_small", MUL, 32'h0000_0007, 32'h0000_0006, 32'h0000_002a);
		add_vector("mul_mixed", MUL, 32'hffff_fffd, 32'h0000_0005, 32'hffff_fff1);
		add_vector("mul_wrap", MUL, 32'h1234_5678, 32'h0000_0010, 32'h2345_6780);
		add_vector("mulh_min_min", MULH, 32'h8000_0000, 32'h8000_0000, 32'h4000_0000);
		add_vector("mulh_ones", MULH, 32'hffff_ffff, 32'hffff_ffff, 32'h0000_0000);
		add_vector("mulh_min_max", MULH, 32'h8000_0000, 32'h7fff_ffff, 32'hc000_0000);
		add_vector("mulhsu_ones", MULHSU, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff);
		add_vector("mulhsu_min_min", MULHSU, 32'h8000_0000, 32'h8000_0000, 32'hc000_0000);
		add_vector("mulhu_ones", MULHU, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_fffe);
		add_vector("mulhu_min_min", MULHU, 32'h8000_0000, 32'h8000_0000, 32'h4000_0000);
		add_vector("div_neg", DIV, 32'hffff_fff9, 32'h0000_0002, 32'hffff_fffd);
		add_vector("div_zero", DIV, 32'hffff_edcc, 32'h0000_0000, 32'hffff_ffff);
		add_vector("div_overflow", DIV, 32'h8000_0000, 32'hffff_ffff, 32'h8000_0000);
		add_vector("divu_zero", DIVU, 32'h0000_0005, 32'h0000_0000, 32'hffff_ffff);
		add_vector("divu_big", DIVU, 32'hffff_ffff, 32'h0000_0002, 32'h7fff_ffff);
		add_vector("rem_neg", REM, 32'hffff_fff9, 32'h0000_0002, 32'hffff_ffff);
		add_vector("rem_zero", REM, 32'hffff_fff9, 32'h0000_0000, 32'hffff_fff9);
		add_vector("rem_overflow", REM, 32'h8000_0000, 32'hffff_ffff, 32'h0000_0000);
		add_vector("remu_zero", REMU, 32'h0000_1234, 32'h0000_0000, 32'h0000_1234);
		add_vector("remu_small", REMU, 32'h0000_0064, 32'h0000_0007, 32'h0000_0002);

		foreach (vectors[k]) begin
			run_op(vector_names[k], vectors[k].funct3, vectors[k].rs1, vectors[k].rs2,
				vectors[k].rd);
		end

		for (i = 0; i < 40; i++) begin
			f3 = 3'($random(seed));
			a = $random(seed);
			b = $random(seed);
			// Small divisors give quotients with many significant bits
			if (f3[2] && b[0]) begin
				b = b >> 20;
			end
			run_op($sformatf("random_%0d", i), f3, a, b, model_rd(f3, a, b));
		end

		run_unclaimed("add_insn", encode_insn(7'b0000000, MUL, 7'b0110011));
		run_unclaimed("op_imm_insn", encode_insn(7'b0000001, DIV, 7'b0010011));

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// File: tb.f
pcpi_pkg.sv
muldiv_pkg.sv
mul_18x18.sv
pcpi_fastmul_dsp.sv
pcpi_div_seq.sv
pcpi_resp_merge.sv
pcpi_muldiv.sv
pcpi_muldiv_chk.sv
tb_pcpi_muldiv.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_pcpi_muldiv \
	-f tb.f -o sim_tb \
	&& ./obj_dir/sim_tb | tee /dev/stderr | grep -q "^TB PASSED$" \
	&& echo "simulation run ok" \
	|| { echo "simulation run not ok"; exit 1; }
